// ==== hw/ExecuteUnit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "core_params.svh"

module ExecuteUnit (
    input  logic                CLK,
    input  logic                rstN,
    FetchBus.receiver           fetchIn,
    output logic                redirectValid,
    output logic [`XLEN-1:0]    redirectPc,
    output logic                retireValid,
    output logic [`XLEN-1:0]    retirePc,
    output core_pkg::instWord_u retireInst,
    output logic [4:0]          retireRd,
    output logic [`XLEN-1:0]    retireData
);
    import core_pkg::*;

    localparam int DAW = $clog2(`DMEM_DEPTH);

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_SLT = 3'd4;

    instWord_u        inst;
    logic             accept;
    logic             loadPending;      // Second cycle of lw
    logic             regWrite;
    logic             aluSrc;
    logic             memWrite;
    logic             memToReg;
    logic             branch;
    logic [1:0]       aluOp;
    logic [2:0]       aluCtl;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] immB;
    logic [`XLEN-1:0] aluB;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] nextPc;
    logic [`XLEN-1:0] memRdata;
    logic [`XLEN-1:0] dmem [`DMEM_DEPTH];
    logic             taken;
    logic             rfWriteEn;
    logic [4:0]       rfWriteAddr;
    logic [`XLEN-1:0] rfWriteData;

    assign inst          = fetchIn.inst;
    assign fetchIn.ready = !loadPending;
    assign accept        = fetchIn.valid && fetchIn.ready;

    // Main control from opcode
    always_comb begin
        regWrite = 1'b0;
        aluSrc   = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        branch   = 1'b0;
        aluOp    = 2'b00;                                   // Address add
        case (inst.rView.opcode)
            `OP_RTYPE:  begin regWrite = 1'b1; aluOp = 2'b10; end
            `OP_ITYPE:  begin regWrite = 1'b1; aluSrc = 1'b1; end
            `OP_LOAD:   begin regWrite = 1'b1; aluSrc = 1'b1; memToReg = 1'b1; end
            `OP_STORE:  begin aluSrc = 1'b1; memWrite = 1'b1; end
            `OP_BRANCH: begin branch = 1'b1; aluOp = 2'b01; end  // Compare by subtract
            default:    aluOp = 2'b00;
        endcase
    end

    // ALU control
    always_comb begin
        case (aluOp)
            2'b00:   aluCtl = ALU_ADD;
            2'b01:   aluCtl = ALU_SUB;
            default: begin
                case ({inst.rView.funct7, inst.rView.funct3})
                    {`F7_SUB, `F3_SUB}: aluCtl = ALU_SUB;
                    {`F7_AND, `F3_AND}: aluCtl = ALU_AND;
                    {`F7_OR,  `F3_OR}:  aluCtl = ALU_OR;
                    {`F7_SLT, `F3_SLT}: aluCtl = ALU_SLT;
                    {`F7_ADD, `F3_ADD}: aluCtl = ALU_ADD;
                    default:            aluCtl = ALU_ADD;
                endcase
            end
        endcase
    end

    RegisterFile regFile (
        .CLK       (CLK),
        .rstN      (rstN),
        .readAddr1 (inst.rView.rs1),
        .readAddr2 (inst.rView.rs2),
        .writeEn   (rfWriteEn),
        .writeAddr (rfWriteAddr),
        .writeData (rfWriteData),
        .readData1 (rs1Data),
        .readData2 (rs2Data)
    );

    // Immediates; S and B are reassembled from the R view fields
    assign immI = {{(`XLEN-12){inst.iView.imm[11]}}, inst.iView.imm};
    assign immS = {{(`XLEN-12){inst.rView.funct7[6]}}, inst.rView.funct7, inst.rView.rd};
    assign immB = {{(`XLEN-13){inst.rView.funct7[6]}}, inst.rView.funct7[6], inst.rView.rd[0],
                   inst.rView.funct7[5:0], inst.rView.rd[4:1], 1'b0};
    assign aluB = aluSrc ? (memWrite ? immS : immI) : rs2Data;

    always_comb begin
        case (aluCtl)
            ALU_SUB: aluResult = rs1Data - aluB;
            ALU_AND: aluResult = rs1Data & aluB;
            ALU_OR:  aluResult = rs1Data | aluB;
            ALU_SLT: aluResult = {{(`XLEN-1){1'b0}}, $signed(rs1Data) < $signed(aluB)};
            ALU_ADD: aluResult = rs1Data + aluB;
            default: aluResult = rs1Data + aluB;
        endcase
    end

    // beq resolution
    assign taken         = branch && (aluResult == '0);
    assign redirectValid = accept && taken;
    assign redirectPc    = fetchIn.pc + immB;
    assign nextPc        = taken ? redirectPc : fetchIn.pc + 4;

    // Data memory with synchronous read
    always_ff @(posedge CLK) begin
        if (accept && memWrite) begin
            dmem[aluResult[DAW+1:2]] <= rs2Data;
        end
        if (accept && memToReg) begin
            memRdata <= dmem[aluResult[DAW+1:2]];
        end
    end

    // Load writes back in its second cycle, rd is already in retireRd
    assign rfWriteEn   = (accept && regWrite && !memToReg) || loadPending;
    assign rfWriteAddr = loadPending ? retireRd : inst.rView.rd;
    assign rfWriteData = loadPending ? memRdata : aluResult;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            loadPending <= 1'b0;
            retireValid <= 1'b0;
        end else begin
            loadPending <= accept && memToReg;
            retireValid <= (accept && !memToReg) || loadPending;
        end
    end

    // Retire record
    always_ff @(posedge CLK) begin
        if (loadPending) begin
            retireData <= (retireRd == 5'd0) ? '0 : memRdata;
        end else if (accept) begin
            retirePc   <= fetchIn.pc;
            retireInst <= inst;
            retireRd   <= regWrite ? inst.rView.rd : 5'd0;
            if (memWrite) begin
                retireData <= rs2Data;                      // Store data
            end else if (branch) begin
                retireData <= nextPc;
            end else if (regWrite && inst.rView.rd != 5'd0) begin
                retireData <= aluResult;
            end else begin
                retireData <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/FetchBus.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "core_params.svh"

interface FetchBus;
    import core_pkg::*;

    logic             valid;    // Sender has an item
    logic             ready;    // Receiver can take it
    logic [`XLEN-1:0] pc;
    instWord_u        inst;

    // Payload is held steady while valid waits for ready
    modport sender (output valid, output pc, output inst, input ready);
    modport receiver (input valid, input pc, input inst, output ready);

endinterface

`default_nettype wire

// ==== hw/FetchQueue.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "core_params.svh"

module FetchQueue (
    input  logic      CLK,
    input  logic      rstN,
    input  logic      redirectValid,
    FetchBus.receiver fetchIn,
    FetchBus.sender   fetchOut
);
    import core_pkg::*;

    localparam int AW = $clog2(`FQ_DEPTH);

    logic [`XLEN-1:0] pcBuf [`FQ_DEPTH];
    instWord_u        instBuf [`FQ_DEPTH];
    logic [AW-1:0]    wrPtr;
    logic [AW-1:0]    rdPtr;
    logic [AW:0]      count;            // One extra bit to tell full from empty
    logic             push;
    logic             pop;

    assign fetchIn.ready  = (count != `FQ_DEPTH);
    assign fetchOut.valid = (count != '0);
    assign fetchOut.pc    = pcBuf[rdPtr];
    assign fetchOut.inst  = instBuf[rdPtr];

    assign push = fetchIn.valid && fetchIn.ready;
    assign pop  = fetchOut.valid && fetchOut.ready;

    // Storage
    always_ff @(posedge CLK) begin
        if (push) begin
            pcBuf[wrPtr]   <= fetchIn.pc;
            instBuf[wrPtr] <= fetchIn.inst;
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (redirectValid) begin
            // Flush everything fetched past the branch
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;  // Wraps at depth
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/InstFetch.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "core_params.svh"

module InstFetch (
    input  logic                           CLK,
    input  logic                           rstN,
    input  logic                           run,
    input  logic                           loadEn,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] loadAddr,    // Word index
    input  logic [`XLEN-1:0]               loadData,
    input  logic                           redirectValid,
    input  logic [`XLEN-1:0]               redirectPc,
    FetchBus.sender                        fetchOut
);
    import core_pkg::*;

    localparam int IAW = $clog2(`IMEM_DEPTH);

    instWord_u        imem [`IMEM_DEPTH];
    logic [`XLEN-1:0] pc;
    logic             slotFree;
    logic             fetchNow;

    // Item register empty, or its item leaves on this edge
    assign slotFree = !fetchOut.valid || fetchOut.ready;
    assign fetchNow = run && slotFree && !redirectValid;

    // Program load port
    always_ff @(posedge CLK) begin
        if (loadEn) begin
            imem[loadAddr] <= instWord_u'(loadData);
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc             <= '0;
            fetchOut.valid <= 1'b0;
        end else if (redirectValid) begin
            // Wrong-path item is dropped, target is fetched next cycle
            pc             <= redirectPc;
            fetchOut.valid <= 1'b0;
        end else if (slotFree) begin
            fetchOut.valid <= run;
            if (run) begin
                pc <= pc + 4;
            end
        end
    end

    // Item payload
    always_ff @(posedge CLK) begin
        if (fetchNow) begin
            fetchOut.pc   <= pc;
            fetchOut.inst <= imem[pc[IAW+1:2]];   // Byte PC to word index
        end
    end

endmodule

`default_nettype wire

// ==== hw/RegisterFile.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "core_params.svh"

module RegisterFile (
    input  logic             CLK,
    input  logic             rstN,
    input  logic [4:0]       readAddr1,
    input  logic [4:0]       readAddr2,
    input  logic             writeEn,
    input  logic [4:0]       writeAddr,
    input  logic [`XLEN-1:0] writeData,
    output logic [`XLEN-1:0] readData1,
    output logic [`XLEN-1:0] readData2
);

    logic [`XLEN-1:0] regs [1:31];      // x0 has no storage

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;   // x0 never written
        end
    end

    // Asynchronous reads, x0 hardwired
    assign readData1 = (readAddr1 == 5'd0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == 5'd0) ? '0 : regs[readAddr2];

endmodule

`default_nettype wire

// ==== hw/SingleCpu.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "core_params.svh"

module SingleCpu (
    input  logic                           CLK,
    input  logic                           rstN,
    input  logic                           run,
    input  logic                           loadEn,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] loadAddr,
    input  logic [`XLEN-1:0]               loadData,
    output logic                           retireValid,
    output logic [`XLEN-1:0]               retirePc,
    output core_pkg::instWord_u            retireInst,
    output logic [4:0]                     retireRd,
    output logic [`XLEN-1:0]               retireData
);

    FetchBus fetchIn ();    // Fetch to queue
    FetchBus fetchOut ();   // Queue to execute

    logic             redirectValid;
    logic [`XLEN-1:0] redirectPc;

    InstFetch instFetch (
        .CLK           (CLK),
        .rstN          (rstN),
        .run           (run),
        .loadEn        (loadEn),
        .loadAddr      (loadAddr),
        .loadData      (loadData),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .fetchOut      (fetchIn.sender)
    );

    FetchQueue fetchQueue (
        .CLK           (CLK),
        .rstN          (rstN),
        .redirectValid (redirectValid),
        .fetchIn       (fetchIn.receiver),
        .fetchOut      (fetchOut.sender)
    );

    ExecuteUnit executeUnit (
        .CLK           (CLK),
        .rstN          (rstN),
        .fetchIn       (fetchOut.receiver),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .retireValid   (retireValid),
        .retirePc      (retirePc),
        .retireInst    (retireInst),
        .retireRd      (retireRd),
        .retireData    (retireData)
    );

endmodule

`default_nettype wire

// ==== hw/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath and memory sizes
`define XLEN        32
`define IMEM_DEPTH  64      // Words
`define DMEM_DEPTH  64      // Words
`define FQ_DEPTH    4       // Power of two, at least 2

// RV32I major opcodes
`define OP_RTYPE    7'b0110011
`define OP_ITYPE    7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011

// R-type function codes
`define F3_ADD      3'b000
`define F3_SUB      3'b000
`define F3_SLT      3'b010
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F7_ADD      7'b0000000
`define F7_SUB      7'b0100000
`define F7_SLT      7'b0000000
`define F7_OR       7'b0000000
`define F7_AND      7'b0000000

`endif

// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // Instruction word seen in R layout or I layout
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rView;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iView;
    } instWord_u;

endpackage

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/core_pkg.sv
hw/FetchBus.sv
hw/InstFetch.sv
hw/FetchQueue.sv
hw/RegisterFile.sv
hw/ExecuteUnit.sv
hw/SingleCpu.sv
verification/SingleCpuTb.sv

// ==== verification/SingleCpuTb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "core_params.svh"

module SingleCpuTb;
    import core_pkg::*;

    localparam int IAW            = $clog2(`IMEM_DEPTH);
    localparam int RETIRE_TIMEOUT = 200;    // Cycles per retire

    logic             CLK;
    logic             rstN;
    logic             run;
    logic             loadEn;
    logic [IAW-1:0]   loadAddr;
    logic [`XLEN-1:0] loadData;
    logic             retireValid;
    logic [`XLEN-1:0] retirePc;
    instWord_u        retireInst;
    logic [4:0]       retireRd;
    logic [`XLEN-1:0] retireData;

    // Program image and expected retire records from the trace
    logic [IAW-1:0]   progAddr [$];
    logic [`XLEN-1:0] progWord [$];
    logic [`XLEN-1:0] expPc [$];
    instWord_u        expInst [$];
    logic [4:0]       expRd [$];
    logic [`XLEN-1:0] expData [$];

    SingleCpu UUT (
        .CLK         (CLK),
        .rstN        (rstN),
        .run         (run),
        .loadEn      (loadEn),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireInst  (retireInst),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    always #4 CLK = ~CLK;   // 8 ns period

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkWord(input string name, input int idx,
                             input logic [`XLEN-1:0] expected, input logic [`XLEN-1:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("Error at %0t ns: %s of retire %0d expected %h, got %h",
                               $time, name, idx, expected, actual));
        end
    endtask

    task automatic checkInst(input string name, input int idx,
                             input instWord_u expected, input instWord_u actual);
        if (actual !== expected) begin
            abortRun($sformatf("Error at %0t ns: %s of retire %0d expected %h, got %h",
                               $time, name, idx, expected, actual));
        end
    endtask

    task automatic checkReg(input string name, input int idx,
                            input logic [4:0] expected, input logic [4:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("Error at %0t ns: %s of retire %0d expected %0d, got %0d",
                               $time, name, idx, expected, actual));
        end
    endtask

    // Parses P and R lines and skips # comments
    task automatic readTrace();
        int          fd;
        int          c;
        int          n;
        logic        bad;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        bad = 1'b0;
        fd  = $fopen("verification/core_trace.txt", "r");
        if (fd == 0) begin
            abortRun("Could not open the trace file verification/core_trace.txt");
        end else begin
            c = $fgetc(fd);
            while (c != -1 && !bad) begin
                case (c)
                    "#": begin
                        while (c != "\n" && c != -1) begin
                            c = $fgetc(fd);
                        end
                    end
                    "P": begin
                        n = $fscanf(fd, " %h %h", f1, f2);
                        bad = (n != 2);
                        progAddr.push_back(f1[IAW-1:0]);    // Word index
                        progWord.push_back(f2);
                    end
                    "R": begin
                        n = $fscanf(fd, " %h %h %h %h", f1, f2, f3, f4);
                        bad = (n != 4);
                        expPc.push_back(f1);
                        expInst.push_back(instWord_u'(f2));
                        expRd.push_back(f3[4:0]);
                        expData.push_back(f4);
                    end
                    " ", "\t", "\n", "\r": ;
                    default: bad = 1'b1;
                endcase
                c = $fgetc(fd);
            end
            $fclose(fd);
            if (bad || expPc.size() == 0 || progWord.size() == 0) begin
                abortRun("The trace file is malformed or holds no program or records");
            end
        end
    endtask

    task automatic expectIdle(input string phase);
        if (retireValid !== 1'b0) begin
            abortRun($sformatf("retireValid was high during %s", phase));
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progWord.size(); i++) begin
            @(posedge CLK);
            expectIdle("program load");
            loadEn   <= 1'b1;
            loadAddr <= progAddr[i];
            loadData <= progWord[i];
        end
        @(posedge CLK);
        expectIdle("program load");
        loadEn <= 1'b0;
        @(posedge CLK);
        expectIdle("program load");
        run <= 1'b1;        // Fetch starts on the next edge
    endtask

    // Read at the edge, the record still holds the previous cycle's values
    task automatic waitRetire(input int idx);
        int cycles;
        cycles = 0;
        @(posedge CLK);
        while (retireValid !== 1'b1 && cycles < RETIRE_TIMEOUT) begin
            cycles++;
            @(posedge CLK);
        end
        if (retireValid !== 1'b1) begin
            abortRun($sformatf("Retire %0d with pc %h never arrived within %0d cycles",
                               idx, expPc[idx], RETIRE_TIMEOUT));
        end
    endtask

    initial begin
        CLK      = 1'b0;
        rstN     = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        readTrace();
        for (int i = 0; i < 8; i++) begin
            @(posedge CLK);
            if (i > 0) expectIdle("reset");     // Outputs unknown before the first edge
        end
        rstN <= 1'b1;
        loadProgram();
        for (int i = 0; i < expPc.size(); i++) begin
            waitRetire(i);
            checkWord("retirePc", i, expPc[i], retirePc);
            checkInst("retireInst", i, expInst[i], retireInst);
            checkReg("retireRd", i, expRd[i], retireRd);
            checkWord("retireData", i, expData[i], retireData);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/core_trace.txt ====
# P word_index instruction   (program image, hex)
# R pc instruction rd data   (expected retire records in order, hex)
P 00 00D00093
P 01 FFA00113
P 02 002081B3
P 03 40208233
P 04 0020F2B3
P 05 0020E333
P 06 0020A3B3
P 07 00112433
P 08 00602423
P 09 00802483
P 0A 00802503
P 0B 00402623
P 0C 00C02583
P 0D 03700013
P 0E 00300633
P 0F 00C18663
P 10 00100693
P 11 00200713
P 12 00208463
P 13 FFF58793
P 14 00000063
R 00000000 00D00093 01 0000000D
R 00000004 FFA00113 02 FFFFFFFA
R 00000008 002081B3 03 00000007
R 0000000C 40208233 04 00000013
R 00000010 0020F2B3 05 00000008
R 00000014 0020E333 06 FFFFFFFF
R 00000018 0020A3B3 07 00000000
R 0000001C 00112433 08 00000001
R 00000020 00602423 00 FFFFFFFF
R 00000024 00802483 09 FFFFFFFF
R 00000028 00802503 0A FFFFFFFF
R 0000002C 00402623 00 00000013
R 00000030 00C02583 0B 00000013
R 00000034 03700013 00 00000000
R 00000038 00300633 0C 00000007
R 0000003C 00C18663 00 00000048
R 00000048 00208463 00 0000004C
R 0000004C FFF58793 0F 00000012
R 00000050 00000063 00 00000050
R 00000050 00000063 00 00000050
